// ==== logic/irq_proto_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Processor-side protocol of the interrupt controller
////////////////////////////////////////////////////////////////////////////

package irq_proto_pkg;

    // Request line count and field widths
    localparam int NUM_SRC  = 8;                   // One processor, eight sources
    localparam int SRC_ID_W = 3;                   // Fixed by the 5-bit codes below
    localparam int CODE_W   = 5;                   // Upper part of the bus word

    typedef logic [SRC_ID_W-1:0] src_id_t;         // Source id
    typedef logic [NUM_SRC-1:0]  src_vec_t;        // One request bit per source
    typedef logic [CODE_W-1:0]   cond_code_t;      // Condition code

    // Word on intr_bus and on intr_ack_bus
    typedef struct packed {
        cond_code_t code;                          // Bits 7..3
        src_id_t    id;                            // Bits 2..0
    } bus_word_t;

    // Command on intr_mode, anything else is invalid
    typedef enum logic [1:0] {
        MODE_POLL = 2'b01,                         // Fixed order scan
        MODE_PRIO = 2'b10                          // Table driven search
    } irq_mode_t;

    // Vector codes, controller to processor
    localparam cond_code_t CODE_VEC_POLL  = 5'b01011;
    localparam cond_code_t CODE_VEC_PRIO  = 5'b10011;

    // End-of-service codes, processor to controller
    localparam cond_code_t CODE_DONE_POLL = 5'b10100;
    localparam cond_code_t CODE_DONE_PRIO = 5'b01100;

endpackage

`default_nettype wire

// ==== logic/irq_core_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Controller internals shared between the RTL blocks
////////////////////////////////////////////////////////////////////////////

package irq_core_pkg;

    // Eight source ids, entry 0 is the highest priority (bits 2..0)
    typedef irq_proto_pkg::src_id_t [irq_proto_pkg::NUM_SRC-1:0] prio_table_t;

    // Controller states, both modes run through the same sequence
    typedef enum logic [3:0] {
        ST_RESET    = 4'd0,                        // One cycle after reset
        ST_COMMAND  = 4'd1,                        // Wait for a valid mode
        ST_DISPATCH = 4'd2,                        // Recheck mode, clear selector
        ST_SEARCH   = 4'd3,                        // Look for a request
        ST_VEC_SEND = 4'd4,                        // intr_out high, wait first ack
        ST_VEC_ACK  = 4'd5,                        // Vector on bus, wait second ack
        ST_ISR_WAIT = 4'd6                         // Wait end-of-service word
    } ctrl_state_t;

    // Control to selector
    typedef struct packed {
        logic clear;                               // Zero scan index and held id
        logic search;                              // Evaluate requests this cycle
        logic prio;                                // Priority rule when set
    } sel_cmd_t;

    // Selector to control
    typedef struct packed {
        logic                    hit;              // Single-cycle strobe
        irq_proto_pkg::src_id_t  id;               // Held selected source
    } grant_t;

endpackage

`default_nettype wire

// ==== logic/irq_prio_table.sv ====
`default_nettype none

module irq_prio_table (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       table_load,  // One cycle in the command state
    input  irq_core_pkg::prio_table_t  table_in,
    output irq_core_pkg::prio_table_t  table_q      // Search order, entry 0 first
);

    // Eight id registers, all loaded together
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            for (int i = 0; i < irq_proto_pkg::NUM_SRC; i++) begin
                table_q[i] <= '0;
            end
        end else if (table_load) begin
            for (int i = 0; i < irq_proto_pkg::NUM_SRC; i++) begin
                table_q[i] <= table_in[i];       // Entry i from bits 3i+2..3i
            end
        end
    end

    // Polling mode never reads the table, so it keeps its last load

endmodule

`default_nettype wire

// ==== logic/irq_source_select.sv ====
`default_nettype none

module irq_source_select (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  irq_core_pkg::sel_cmd_t     sel_cmd,
    input  irq_proto_pkg::src_vec_t    intr_rq,
    input  irq_core_pkg::prio_table_t  table_q,
    output irq_core_pkg::grant_t       grant
);

    irq_proto_pkg::src_id_t scan_idx;            // Polling position
    irq_proto_pkg::src_id_t prio_id;             // First requesting table entry
    logic                   prio_found;
    logic                   poll_found;

    ////////////////////////////////////////////////////////////////////////////
    // Priority search over the table, entry 0 wins
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        prio_found = 1'b0;
        prio_id    = '0;
        for (int i = 0; i < irq_proto_pkg::NUM_SRC; i++) begin
            if (!prio_found && intr_rq[table_q[i]]) begin
                prio_found = 1'b1;
                prio_id    = table_q[i];
            end
        end
    end

    // Polling looks at one source only
    assign poll_found = intr_rq[scan_idx];

    ////////////////////////////////////////////////////////////////////////////
    // Scan index, held id and hit strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            scan_idx  <= '0;
            grant.id  <= '0;
            grant.hit <= 1'b0;
        end else if (sel_cmd.clear) begin       // Start of a new mode
            scan_idx  <= '0;
            grant.id  <= '0;
            grant.hit <= 1'b0;
        end else if (sel_cmd.search && !grant.hit) begin
            if (sel_cmd.prio) begin
                if (prio_found) begin
                    grant.hit <= 1'b1;
                    grant.id  <= prio_id;
                end
            end else if (poll_found) begin
                grant.hit <= 1'b1;
                grant.id  <= scan_idx;           // Index stays here after service
            end else begin
                scan_idx <= scan_idx + 3'd1;     // Wraps after 7
            end
        end else begin
            grant.hit <= 1'b0;                   // Strobe lasts one cycle
        end
    end

    // While the strobe is high the control leaves SEARCH, so nothing is
    // evaluated in that cycle and the index does not move

endmodule

`default_nettype wire

// ==== logic/irq_vector_bus.sv ====
`default_nettype none

module irq_vector_bus (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      vec_load,      // First ack of the exchange
    input  logic                      mode_prio,
    input  irq_proto_pkg::src_id_t    sel_id,        // Held id from the selector
    input  irq_proto_pkg::bus_word_t  intr_ack_bus,
    output irq_proto_pkg::bus_word_t  intr_bus,
    output logic                      done_ok        // Level, qualified by the FSM
);

    irq_proto_pkg::cond_code_t vec_code;
    irq_proto_pkg::cond_code_t done_code;
    irq_proto_pkg::bus_word_t  vec_word;
    irq_proto_pkg::bus_word_t  done_word;

    // Codes depend on the held mode
    assign vec_code  = mode_prio ? irq_proto_pkg::CODE_VEC_PRIO
                                 : irq_proto_pkg::CODE_VEC_POLL;
    assign done_code = mode_prio ? irq_proto_pkg::CODE_DONE_PRIO
                                 : irq_proto_pkg::CODE_DONE_POLL;

    assign vec_word.code  = vec_code;
    assign vec_word.id    = sel_id;
    assign done_word.code = done_code;
    assign done_word.id   = sel_id;

    ////////////////////////////////////////////////////////////////////////////
    // Vector register, holds until the next load or reset
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            intr_bus <= '0;                      // Bus reads zero after reset
        end else if (vec_load) begin
            intr_bus <= vec_word;
        end
    end

    // End-of-service check, code and id must both match
    assign done_ok = (intr_ack_bus == done_word);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl_fsm.sv ====
`default_nettype none

module irq_ctrl_fsm (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    intr_in,     // Active low, sampled on clk_in
    input  logic [1:0]              intr_mode,
    input  irq_core_pkg::grant_t    grant,
    input  logic                    done_ok,     // Ack word matches, not yet qualified
    output irq_core_pkg::sel_cmd_t  sel_cmd,
    output logic                    table_load,
    output logic                    vec_load,
    output logic                    mode_prio,
    output logic                    intr_out
);

    irq_core_pkg::ctrl_state_t state_q, state_d;
    logic                      mode_prio_d;
    logic                      intr_out_d;
    logic                      mode_valid;        // intr_mode is a known command

    assign mode_valid = (intr_mode == irq_proto_pkg::MODE_POLL) ||
                        (intr_mode == irq_proto_pkg::MODE_PRIO);

    ////////////////////////////////////////////////////////////////////////////
    // State, mode and interrupt output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q   <= irq_core_pkg::ST_RESET;
            mode_prio <= 1'b0;
            intr_out  <= 1'b0;                   // No interrupt after reset
        end else begin
            state_q   <= state_d;
            mode_prio <= mode_prio_d;
            intr_out  <= intr_out_d;
        end
    end

    // Selector command follows the state directly
    assign sel_cmd.clear  = (state_q == irq_core_pkg::ST_DISPATCH);
    assign sel_cmd.search = (state_q == irq_core_pkg::ST_SEARCH);
    assign sel_cmd.prio   = mode_prio;           // Held mode picks the search rule

    // Table is captured on the edge that leaves the command state
    assign table_load = (state_q == irq_core_pkg::ST_COMMAND) &&
                        (intr_mode == irq_proto_pkg::MODE_PRIO);

    // Vector goes out on the first acknowledge
    assign vec_load = (state_q == irq_core_pkg::ST_VEC_SEND) && !intr_in;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;                   // Hold by default
        mode_prio_d = mode_prio;
        intr_out_d  = intr_out;

        case (state_q)
            irq_core_pkg::ST_RESET: begin
                intr_out_d = 1'b0;
                state_d    = irq_core_pkg::ST_COMMAND;
            end

            // Wait here until a valid mode shows up
            irq_core_pkg::ST_COMMAND: begin
                if (mode_valid) begin
                    mode_prio_d = (intr_mode == irq_proto_pkg::MODE_PRIO);
                    state_d     = irq_core_pkg::ST_DISPATCH;
                end
            end

            // Mode is sampled a second time, a bad value restarts
            irq_core_pkg::ST_DISPATCH: begin
                if (mode_valid) begin
                    mode_prio_d = (intr_mode == irq_proto_pkg::MODE_PRIO);
                    state_d     = irq_core_pkg::ST_SEARCH;
                end else begin
                    state_d = irq_core_pkg::ST_RESET;
                end
            end

            // Selector reports a hit one cycle after it found it
            irq_core_pkg::ST_SEARCH: begin
                if (grant.hit) begin
                    intr_out_d = 1'b1;           // Rises with entry to VEC_SEND
                    state_d    = irq_core_pkg::ST_VEC_SEND;
                end
            end

            // First low ack drops intr_out and loads the vector
            irq_core_pkg::ST_VEC_SEND: begin
                if (!intr_in) begin
                    intr_out_d = 1'b0;
                    state_d    = irq_core_pkg::ST_VEC_ACK;
                end
            end

            irq_core_pkg::ST_VEC_ACK: begin
                if (!intr_in) begin              // Processor took the vector
                    state_d = irq_core_pkg::ST_ISR_WAIT;
                end
            end

            // Only a matching word with intr_in low ends the service
            irq_core_pkg::ST_ISR_WAIT: begin
                if (!intr_in && done_ok) begin
                    state_d = irq_core_pkg::ST_SEARCH;
                end
            end

            default: begin                       // Unused codes restart
                intr_out_d = 1'b0;
                state_d    = irq_core_pkg::ST_RESET;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/irq_ctrl_top.sv ====
`default_nettype none

module irq_ctrl_top (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  irq_proto_pkg::src_vec_t   intr_rq,          // Request lines
    input  logic [1:0]                intr_mode,        // Command word
    input  logic [31:0]               priorities_table, // Only bits 23..0 carry ids
    input  logic                      intr_in,          // Active-low ack from processor
    input  irq_proto_pkg::bus_word_t  intr_ack_bus,     // End-of-service word
    output logic                      intr_out,         // Interrupt to processor
    output irq_proto_pkg::bus_word_t  intr_bus          // Vector to processor
);

    // Control strobes and datapath returns
    irq_core_pkg::sel_cmd_t     sel_cmd;
    irq_core_pkg::grant_t       grant;
    irq_core_pkg::prio_table_t  table_q;
    logic                       table_load;
    logic                       vec_load;
    logic                       mode_prio;
    logic                       done_ok;

    irq_ctrl_fsm i_fsm (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .intr_in    (intr_in),
        .intr_mode  (intr_mode),
        .grant      (grant),
        .done_ok    (done_ok),
        .sel_cmd    (sel_cmd),
        .table_load (table_load),
        .vec_load   (vec_load),
        .mode_prio  (mode_prio),
        .intr_out   (intr_out)
    );

    // Lower 24 bits hold the eight 3-bit entries
    irq_prio_table i_table (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .table_load (table_load),
        .table_in   (priorities_table[23:0]),
        .table_q    (table_q)
    );

    irq_source_select i_select (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .sel_cmd (sel_cmd),
        .intr_rq (intr_rq),
        .table_q (table_q),
        .grant   (grant)
    );

    irq_vector_bus i_vector (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .vec_load     (vec_load),
        .mode_prio    (mode_prio),
        .sel_id       (grant.id),
        .intr_ack_bus (intr_ack_bus),
        .intr_bus     (intr_bus),
        .done_ok      (done_ok)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk_in,
    output logic rst_in                          // Power-on reset only
);

    // Period of 10 time units
    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // Four cycles of reset, released on a falling edge
    initial begin
        rst_in = 1'b1;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/tb_irq_ctrl.sv ====
`default_nettype none

module tb_irq_ctrl;

    // Codes as the protocol defines them
    localparam logic [4:0] VEC_POLL  = 5'b01011;
    localparam logic [4:0] VEC_PRIO  = 5'b10011;
    localparam logic [4:0] DONE_POLL = 5'b10100;
    localparam logic [4:0] DONE_PRIO = 5'b01100;
    localparam int         WAIT_MAX  = 50;       // Cycles per wait loop

    logic                      clk_in;
    logic                      por_rst;
    logic                      test_rst;         // Reset between tests
    logic                      rst_in;
    irq_proto_pkg::src_vec_t   intr_rq;
    logic [1:0]                intr_mode;
    logic [31:0]               priorities_table;
    logic                      intr_in;
    irq_proto_pkg::bus_word_t  intr_ack_bus;
    logic                      intr_out;
    irq_proto_pkg::bus_word_t  intr_bus;
    logic [31:0]               lcg_state;

    assign rst_in = por_rst | test_rst;

    tb_clock_gen i_clk (
        .clk_in (clk_in),
        .rst_in (por_rst)
    );

    irq_ctrl_top i_dut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_rq          (intr_rq),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .intr_in          (intr_in),
        .intr_ack_bus     (intr_ack_bus),
        .intr_out         (intr_out),
        .intr_bus         (intr_bus)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_bus_word(input string name, input irq_proto_pkg::bus_word_t actual,
                                  input irq_proto_pkg::bus_word_t expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                    name, actual, expected));
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                    name, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // LCG, constants from the usual 32-bit recipe
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic irq_proto_pkg::bus_word_t make_word(input logic [4:0] code,
                                                           input logic [2:0] id);
        irq_proto_pkg::bus_word_t w;
        w.code = code;
        w.id   = id;
        return w;
    endfunction

    // First table entry whose request line is set, entry 0 first
    function automatic logic [2:0] first_requested(input irq_core_pkg::prio_table_t tbl,
                                                   input logic [7:0] rq);
        for (int i = 0; i < 8; i++) begin
            if (rq[tbl[i]]) begin
                return tbl[i];
            end
        end
        return 3'd0;
    endfunction

    // Shuffle of ids 0..7
    task automatic make_perm_table(output irq_core_pkg::prio_table_t tbl);
        logic [2:0] tmp;
        int         j;
        for (int i = 0; i < 8; i++) begin
            tbl[i] = 3'(i);
        end
        for (int i = 7; i > 0; i--) begin
            j      = int'((lcg_next() >> 16) % (i + 1));
            tmp    = tbl[i];
            tbl[i] = tbl[j];
            tbl[j] = tmp;
        end
    endtask

    task automatic wait_intr_out(input logic level);
        int cycles;
        cycles = 0;
        while (intr_out !== level && cycles < WAIT_MAX) begin
            @(negedge clk_in);
            cycles++;
        end
        if (intr_out !== level) begin
            stop_on_error($sformatf("Timed out waiting for intr_out to reach %0b", level));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (por_rst !== 1'b0 && cycles < WAIT_MAX) begin
            @(negedge clk_in);
            cycles++;
        end
        if (por_rst !== 1'b0) begin
            stop_on_error("Power-on reset never released");
        end
    endtask

    // Four cycles of reset, inputs back to idle
    task automatic apply_reset();
        @(negedge clk_in);
        test_rst     = 1'b1;
        intr_rq      = '0;
        intr_mode    = 2'b00;
        intr_in      = 1'b1;                     // Ack is active low
        intr_ack_bus = '0;
        repeat (4) @(negedge clk_in);
        test_rst = 1'b0;
    endtask

    // Interrupt up, first ack, vector on the bus
    task automatic start_exchange(input irq_proto_pkg::bus_word_t expected);
        wait_intr_out(1'b1);
        intr_in = 1'b0;
        wait_intr_out(1'b0);                     // Falls on the edge that loads the vector
        check_bus_word("intr_bus", intr_bus, expected);
    endtask

    // intr_in stays low, so VEC_ACK takes one cycle and ISR_WAIT the next
    task automatic finish_exchange(input irq_proto_pkg::bus_word_t done_word,
                                   input logic [7:0] drop_mask);
        intr_rq      = intr_rq & ~drop_mask;
        intr_ack_bus = done_word;
        repeat (2) @(negedge clk_in);
        intr_in      = 1'b1;
        intr_ack_bus = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_idle_after_reset();
        check_level("intr_out", intr_out, 1'b0);
        check_bus_word("intr_bus", intr_bus, make_word(5'd0, 3'd0));
        intr_rq   = 8'h01;
        intr_mode = 2'b00;                       // No valid command
        repeat (20) begin
            @(negedge clk_in);
            check_level("intr_out", intr_out, 1'b0);
        end
        apply_reset();
    endtask

    task automatic test_poll_single();
        intr_mode = 2'b01;
        intr_in   = 1'b1;
        intr_rq   = 8'h20;                       // Source 5
        start_exchange(make_word(VEC_POLL, 3'd5));
        finish_exchange(make_word(DONE_POLL, 3'd5), 8'h20);
        // Scan index was not advanced, so source 5 wins over source 6
        intr_rq = 8'h60;
        start_exchange(make_word(VEC_POLL, 3'd5));
        apply_reset();
    endtask

    task automatic test_poll_order();
        intr_rq   = 8'h48;                       // Sources 3 and 6
        intr_in   = 1'b1;
        intr_mode = 2'b01;
        start_exchange(make_word(VEC_POLL, 3'd3));
        finish_exchange(make_word(DONE_POLL, 3'd3), 8'h08);
        start_exchange(make_word(VEC_POLL, 3'd6));
        finish_exchange(make_word(DONE_POLL, 3'd6), 8'h40);
        apply_reset();
    endtask

    task automatic test_bad_done();
        intr_mode = 2'b01;
        intr_in   = 1'b1;
        intr_rq   = 8'h02;                       // Source 1
        start_exchange(make_word(VEC_POLL, 3'd1));
        intr_rq      = 8'h04;                    // Would be served if service ended
        intr_ack_bus = make_word(DONE_PRIO, 3'd1);
        repeat (5) begin
            @(negedge clk_in);
            check_level("intr_out", intr_out, 1'b0);
        end
        intr_ack_bus = make_word(DONE_POLL, 3'd2);   // Right code, wrong id
        repeat (5) begin
            @(negedge clk_in);
            check_level("intr_out", intr_out, 1'b0);
        end
        finish_exchange(make_word(DONE_POLL, 3'd1), 8'h00);
        start_exchange(make_word(VEC_POLL, 3'd2));
        finish_exchange(make_word(DONE_POLL, 3'd2), 8'h04);
        apply_reset();
    endtask

    task automatic test_prio_mode();
        irq_core_pkg::prio_table_t tbl;
        logic [31:0]               rnd;
        logic [7:0]                rq;
        logic [2:0]                exp_id;
        make_perm_table(tbl);
        priorities_table = {8'h00, tbl};
        intr_mode        = 2'b10;
        intr_in          = 1'b1;
        for (int n = 0; n < 8; n++) begin
            rnd = lcg_next();
            rq  = rnd[23:16];
            if (rq == 8'h00) begin
                rq = 8'h80;                      // Always at least one request
            end
            exp_id  = first_requested(tbl, rq);
            intr_rq = rq;
            start_exchange(make_word(VEC_PRIO, exp_id));
            finish_exchange(make_word(DONE_PRIO, exp_id), 8'hff);
        end
        apply_reset();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lcg_state        = 32'd5;                // Seed
        test_rst         = 1'b0;
        intr_rq          = '0;
        intr_mode        = 2'b00;
        priorities_table = '0;
        intr_in          = 1'b1;
        intr_ack_bus     = '0;
        wait_reset_release();
        test_idle_after_reset();
        test_poll_single();
        test_poll_order();
        test_bad_done();
        test_prio_mode();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/irq_proto_pkg.sv
logic/irq_core_pkg.sv
logic/irq_prio_table.sv
logic/irq_source_select.sv
logic/irq_vector_bus.sv
logic/irq_ctrl_fsm.sv
logic/irq_ctrl_top.sv
bench/tb_clock_gen.sv
bench/tb_irq_ctrl.sv
